// File: list.f
+incdir+dv
logic/cssStylePkg.sv
logic/namedColorTable.sv
logic/colorResolver.sv
logic/styleCtrl.sv
logic/cssColorTop.sv
dv/cssColor_assert.sv
dv/cssColorTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = cssColorTb
FILELIST = list.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# the pipeline status is grep's, so a run without the pass line fails
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir

// File: dv/cssColorRef.svh
`ifndef CSS_COLOR_REF_SVH
`define CSS_COLOR_REF_SVH

// named and system colors with 0 where a code has no entry
function automatic cssStylePkg::rgbaT namedColorRef(input cssStylePkg::cssIdentT ident);
	case (ident)
		cssStylePkg::identAqua: return 32'hFF00FFFF;
		cssStylePkg::identBlack: return 32'hFF000000;
		cssStylePkg::identBlue: return 32'hFF0000FF;
		cssStylePkg::identFuchsia: return 32'hFFFF00FF;
		cssStylePkg::identGray: return 32'hFF808080;
		cssStylePkg::identGreen: return 32'hFF008000;
		cssStylePkg::identGrey: return 32'hFF808080;
		cssStylePkg::identLime: return 32'hFF00FF00;
		cssStylePkg::identMaroon: return 32'hFF800000;
		cssStylePkg::identNavy: return 32'hFF000080;
		cssStylePkg::identOlive: return 32'hFF808000;
		cssStylePkg::identOrange: return 32'hFFFFA500;
		cssStylePkg::identPurple: return 32'hFF800080;
		cssStylePkg::identRed: return 32'hFFFF0000;
		cssStylePkg::identSilver: return 32'hFFC0C0C0;
		cssStylePkg::identTeal: return 32'hFF008080;
		cssStylePkg::identTransparent: return 32'h00000000;
		cssStylePkg::identWhite: return 32'hFFFFFFFF;
		cssStylePkg::identYellow: return 32'hFFFFFF00;
		cssStylePkg::identActiveborder: return 32'hFFFFFFFF;
		cssStylePkg::identActivecaption: return 32'hFFCCCCCC;
		cssStylePkg::identAppworkspace: return 32'hFFFFFFFF;
		cssStylePkg::identBackground: return 32'hFF6363CE;
		cssStylePkg::identButtonface: return 32'hFFC0C0C0;
		cssStylePkg::identButtonhighlight: return 32'hFFDDDDDD;
		cssStylePkg::identButtonshadow: return 32'hFF888888;
		cssStylePkg::identButtontext: return 32'hFF000000;
		cssStylePkg::identCaptiontext: return 32'hFF000000;
		cssStylePkg::identGraytext: return 32'hFF808080;
		cssStylePkg::identHighlight: return 32'hFFB5D5FF;
		cssStylePkg::identHighlighttext: return 32'hFF000000;
		cssStylePkg::identInactiveborder: return 32'hFFFFFFFF;
		cssStylePkg::identInactivecaption: return 32'hFFFFFFFF;
		cssStylePkg::identInactivecaptiontext: return 32'hFF7F7F7F;
		cssStylePkg::identInfobackground: return 32'hFFFBFCC5;
		cssStylePkg::identInfotext: return 32'hFF000000;
		cssStylePkg::identMenu: return 32'hFFC0C0C0;
		default: return 32'h00000000; // menutext and unknown codes
	endcase
endfunction

// expected color for one request with rules applied in priority order
function automatic cssStylePkg::rgbaT expectedColor(input cssStylePkg::styleRequestT r,
	input cssStylePkg::documentColorsT d, input cssStylePkg::rgbaT ringColor);
	if (r.unitType == cssStylePkg::unitRgbColor)
	begin
		return r.rgbColor;
	end
	if (r.unitType != cssStylePkg::unitIdent)
	begin
		return 32'h00000000; // identifier counts as none
	end
	case (r.valueIdent)
		cssStylePkg::identNone: return 32'h00000000;
		cssStylePkg::identWebkitText: return d.textColor;
		cssStylePkg::identWebkitLink:
		begin
			if (r.isLinkElement && r.forVisitedLink)
			begin
				return d.visitedLinkColor;
			end
			return d.linkColor;
		end
		cssStylePkg::identWebkitActivelink: return d.activeLinkColor;
		cssStylePkg::identWebkitFocusRingColor: return ringColor;
		cssStylePkg::identCurrentcolor: return d.inheritedColor;
		default: return namedColorRef(r.valueIdent);
	endcase
endfunction

`endif

// File: dv/cssColorTb.sv
`timescale 1ns/1ps

module cssColorTb;

	localparam int resetCycles = 10;
	localparam int ackLatency = 2; // edges from accept to ack
	localparam int handshakeLimit = 8; // per handshake phase
	// about 115 transactions of at most 10 cycles plus reset with a wide margin
	localparam int timeoutCycles = 3000;
	localparam cssStylePkg::rgbaT focusRing = 32'hFFFFFFFF; // dut0 keeps its default

	logic clk;
	logic arstN;
	logic req;
	cssStylePkg::styleRequestT request;
	cssStylePkg::documentColorsT docColors;
	logic ack;
	cssStylePkg::rgbaT color;

	integer seed;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testChecks = 0; // counts at the end of the previous test
	int testErrors = 0;

	`include "cssColorRef.svh"

	cssColorTop dut0
	(
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.request(request),
		.docColors(docColors),
		.ack(ack),
		.color(color)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
	end

	initial
	begin
		wait (cycleCount >= timeoutCycles);
		$display("run stopped after %0d cycles before all tests finished", cycleCount);
		$display("TEST FAILED");
		$finish;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic finishTest(input string name);
		$display("test %s done: %0d checks, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
		testChecks = checkCount;
		testErrors = errorCount;
	endtask

	// edges until ack reaches level as sampled 1 ns after each edge
	task automatic waitForAck(input logic level, output int edges);
		edges = 0;
		while (ack !== level && edges < handshakeLimit)
		begin
			@(posedge clk);
			#1;
			edges++;
		end
	endtask

	task automatic randomColors(output cssStylePkg::documentColorsT d);
		d.textColor = $random(seed);
		d.linkColor = $random(seed);
		d.visitedLinkColor = $random(seed);
		d.activeLinkColor = $random(seed);
		d.inheritedColor = $random(seed);
	endtask

	function automatic cssStylePkg::styleRequestT makeRequest(
		input cssStylePkg::unitTypeT unitType, input cssStylePkg::cssIdentT ident,
		input cssStylePkg::rgbaT rgb, input logic link, input logic visited);
		cssStylePkg::styleRequestT r;
		r.unitType = unitType;
		r.valueIdent = ident;
		r.rgbColor = rgb;
		r.isLinkElement = link;
		r.forVisitedLink = visited;
		return r;
	endfunction

	// one full four-phase handshake with latency, color and hold checks
	task automatic runTransaction(input string name, input cssStylePkg::styleRequestT r,
		input cssStylePkg::documentColorsT d);
		int edges;
		int extraHold;
		cssStylePkg::rgbaT firstColor;
		@(posedge clk);
		#2;
		request = r;
		docColors = d;
		req = 1'b1;
		@(posedge clk); // edge E
		#1;
		waitForAck(1'b1, edges);
		if (ack !== 1'b1)
		begin
			errorCount++;
			$display("%s: ack did not rise within %0d cycles", name, handshakeLimit);
		end
		checkValue({name, " latency"}, ackLatency, edges);
		checkValue(name, expectedColor(r, d, focusRing), color);
		firstColor = color;
		extraHold = $unsigned($random(seed)) % 3; // slow requester
		repeat (extraHold) @(posedge clk);
		@(posedge clk);
		#2;
		req = 1'b0;
		checkValue({name, " hold"}, firstColor, color);
		waitForAck(1'b0, edges);
		if (ack !== 1'b0)
		begin
			errorCount++;
			$display("%s: ack stayed high after req dropped", name);
		end
	endtask

	initial
	begin
		cssStylePkg::documentColorsT d;
		cssStylePkg::unitTypeT unitType;
		seed = 32'h33f1_aef6;
		clk = 1'b0;
		arstN = 1'b0;
		req = 1'b0;
		request = '0;
		docColors = '0;
		repeat (resetCycles) @(posedge clk);
		#2;
		arstN = 1'b1;
		@(posedge clk);
		#1;
		checkValue("reset ack", 32'd0, {31'd0, ack});
		checkValue("reset color", 32'd0, color);
		finishTest("reset");

		randomColors(d);
		for (int i = 0; i <= 38; i++)
		begin
			runTransaction($sformatf("ident %0d", i),
				makeRequest(cssStylePkg::unitIdent, 10'(i), $random(seed), 1'b0, 1'b0), d);
		end
		for (int i = 0; i < 10; i++)
		begin
			runTransaction($sformatf("unknown ident %0d", i), makeRequest(cssStylePkg::unitIdent,
				10'($unsigned($random(seed)) % 980 + 44), 32'h0, 1'b0, 1'b0), d);
		end
		finishTest("named colors");

		for (int round = 0; round < 3; round++)
		begin
			randomColors(d);
			runTransaction("text", makeRequest(cssStylePkg::unitIdent,
				cssStylePkg::identWebkitText, 32'h0, 1'b0, 1'b0), d);
			runTransaction("activelink", makeRequest(cssStylePkg::unitIdent,
				cssStylePkg::identWebkitActivelink, 32'h0, 1'b1, 1'b0), d);
			runTransaction("focus ring", makeRequest(cssStylePkg::unitIdent,
				cssStylePkg::identWebkitFocusRingColor, 32'h0, 1'b0, 1'b0), d);
			runTransaction("currentcolor", makeRequest(cssStylePkg::unitIdent,
				cssStylePkg::identCurrentcolor, 32'h0, 1'b0, 1'b1), d);
			for (int flags = 0; flags < 4; flags++)
			begin
				runTransaction($sformatf("link flags %0d", flags), makeRequest(cssStylePkg::unitIdent,
					cssStylePkg::identWebkitLink, 32'h0, flags[1], flags[0]), d);
			end
		end
		finishTest("keywords");

		for (int i = 0; i < 20; i++)
		begin
			randomColors(d);
			runTransaction($sformatf("rgb %0d", i), makeRequest(cssStylePkg::unitRgbColor,
				10'($random(seed)), $random(seed), 1'b0, 1'b0), d);
		end
		finishTest("rgb pass-through");

		for (int i = 0; i < 20; i++)
		begin
			unitType = 7'($random(seed));
			if (unitType == cssStylePkg::unitIdent || unitType == cssStylePkg::unitRgbColor)
			begin
				unitType = unitType + 7'd1; // neither ident nor rgb
			end
			runTransaction($sformatf("other unit %0d", i),
				makeRequest(unitType, 10'($random(seed)), $random(seed), 1'b1, 1'b1), d);
		end
		finishTest("other units");

		$display("summary: %0d checks, %0d errors, %0d assertion failures", checkCount,
			errorCount, dut0.assert0.failCount);
		if (errorCount == 0 && dut0.assert0.failCount == 0)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: dv/cssColor_assert.sv
`timescale 1ns/1ps

module cssColorAssert
(
	input logic clk,
	input logic arstN,
	input logic req,
	input logic ack,
	input cssStylePkg::rgbaT color
);

	int failCount = 0; // read by the testbench summary

	ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!arstN) $rose(ack) |-> req)
	else
	begin
		failCount++;
		$error("ack rose while req was low");
	end

	ackHeldWithReq: assert property (@(posedge clk) disable iff (!arstN) (ack && req) |=> ack)
	else
	begin
		failCount++;
		$error("ack fell while req was still high");
	end

	colorStableInHold: assert property (@(posedge clk) disable iff (!arstN)
		(ack && $past(ack)) |-> $stable(color))
	else
	begin
		failCount++;
		$error("color changed while ack was high");
	end

	ackLowInReset: assert property (@(posedge clk) !arstN |-> !ack)
	else
	begin
		failCount++;
		$error("ack was high during reset");
	end

endmodule

bind cssColorTop cssColorAssert assert0
(
	.clk(clk),
	.arstN(arstN),
	.req(req),
	.ack(ack),
	.color(color)
);

// File: logic/cssColorTop.sv
`timescale 1ns/1ps

module cssColorTop
#(
	parameter cssStylePkg::rgbaT focusRingColor = 32'hFFFFFFFF
)
(
	input logic clk,
	input logic arstN,
	input logic req,
	input cssStylePkg::styleRequestT request,
	input cssStylePkg::documentColorsT docColors,
	output logic ack,
	output cssStylePkg::rgbaT color
);

	cssStylePkg::styleRequestT heldRequest;
	cssStylePkg::documentColorsT heldColors;
	cssStylePkg::cssIdentT lookupIdent;
	cssStylePkg::rgbaT namedColor;
	cssStylePkg::rgbaT resolvedColor;

	styleCtrl ctrl0
	(
		.clk(clk),
		.arstN(arstN),
		.req(req),
		.request(request),
		.docColors(docColors),
		.resolvedColor(resolvedColor),
		.heldRequest(heldRequest),
		.heldColors(heldColors),
		.ack(ack),
		.color(color)
	);

	colorResolver #(.focusRingColor(focusRingColor)) resolve0
	(
		.heldRequest(heldRequest),
		.heldColors(heldColors),
		.namedColor(namedColor),
		.lookupIdent(lookupIdent),
		.resolvedColor(resolvedColor)
	);

	namedColorTable table0
	(
		.clk(clk),
		.arstN(arstN),
		.lookupIdent(lookupIdent),
		.namedColor(namedColor)
	);

endmodule

// File: logic/styleCtrl.sv
`timescale 1ns/1ps

module styleCtrl
(
	input logic clk,
	input logic arstN,
	input logic req,
	input cssStylePkg::styleRequestT request,
	input cssStylePkg::documentColorsT docColors,
	input cssStylePkg::rgbaT resolvedColor,
	output cssStylePkg::styleRequestT heldRequest,
	output cssStylePkg::documentColorsT heldColors,
	output logic ack,
	output cssStylePkg::rgbaT color
);

	cssStylePkg::ctrlStateT state;
	cssStylePkg::ctrlStateT stateNext;
	logic accept;

	assign accept = (state == cssStylePkg::stateIdle) && req;

	always_comb
	begin
		stateNext = state;
		case (state)
			cssStylePkg::stateIdle:
			begin
				if (req)
				begin
					stateNext = cssStylePkg::stateLookup;
				end
			end
			cssStylePkg::stateLookup: stateNext = cssStylePkg::stateResolve; // table registers here
			cssStylePkg::stateResolve: stateNext = cssStylePkg::stateHold; // color registers here
			cssStylePkg::stateHold:
			begin
				if (!req)
				begin
					stateNext = cssStylePkg::stateIdle; // requester finished
				end
			end
			default: stateNext = cssStylePkg::stateIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= cssStylePkg::stateIdle;
		end
		else
		begin
			state <= stateNext;
		end
	end

	// request and document colors stay put until the next accept
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			heldRequest <= request;
			heldColors <= docColors;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			color <= '0;
		end
		else if (state == cssStylePkg::stateResolve)
		begin
			color <= resolvedColor; // stable through hold
		end
	end

	assign ack = state == cssStylePkg::stateHold;

endmodule

// File: logic/colorResolver.sv
`timescale 1ns/1ps

module colorResolver
#(
	parameter cssStylePkg::rgbaT focusRingColor = 32'hFFFFFFFF
)
(
	input cssStylePkg::styleRequestT heldRequest,
	input cssStylePkg::documentColorsT heldColors,
	input cssStylePkg::rgbaT namedColor,
	output cssStylePkg::cssIdentT lookupIdent,
	output cssStylePkg::rgbaT resolvedColor
);

	logic isIdent;
	logic isRgbColor;
	logic useVisited;
	cssStylePkg::rgbaT linkColor;
	cssStylePkg::rgbaT identColor;

	assign isIdent = heldRequest.unitType == cssStylePkg::unitIdent;
	assign isRgbColor = heldRequest.unitType == cssStylePkg::unitRgbColor;

	// identifier only counts for an ident unit type
	assign lookupIdent = isIdent ? heldRequest.valueIdent : cssStylePkg::identNone;

	// visited color needs a real link element
	assign useVisited = heldRequest.isLinkElement & heldRequest.forVisitedLink;
	assign linkColor = useVisited ? heldColors.visitedLinkColor : heldColors.linkColor;

	always_comb
	begin
		case (lookupIdent)
			cssStylePkg::identNone: identColor = '0;
			cssStylePkg::identWebkitText: identColor = heldColors.textColor;
			cssStylePkg::identWebkitLink: identColor = linkColor;
			cssStylePkg::identWebkitActivelink: identColor = heldColors.activeLinkColor;
			cssStylePkg::identWebkitFocusRingColor: identColor = focusRingColor; // theme constant
			cssStylePkg::identCurrentcolor: identColor = heldColors.inheritedColor;
			default: identColor = namedColor; // table result or 0 if no entry
		endcase
	end

	// rgb values bypass the identifier path
	assign resolvedColor = isRgbColor ? heldRequest.rgbColor : identColor;

endmodule

// File: logic/namedColorTable.sv
`timescale 1ns/1ps

module namedColorTable
(
	input logic clk,
	input logic arstN,
	input cssStylePkg::cssIdentT lookupIdent,
	output cssStylePkg::rgbaT namedColor
);

	cssStylePkg::rgbaT tableColor;

	always_comb
	begin
		case (lookupIdent)
			cssStylePkg::identAqua: tableColor = 32'hFF00FFFF;
			cssStylePkg::identBlack: tableColor = 32'hFF000000;
			cssStylePkg::identBlue: tableColor = 32'hFF0000FF;
			cssStylePkg::identFuchsia: tableColor = 32'hFFFF00FF;
			cssStylePkg::identGray: tableColor = 32'hFF808080;
			cssStylePkg::identGreen: tableColor = 32'hFF008000;
			cssStylePkg::identGrey: tableColor = 32'hFF808080;
			cssStylePkg::identLime: tableColor = 32'hFF00FF00;
			cssStylePkg::identMaroon: tableColor = 32'hFF800000;
			cssStylePkg::identNavy: tableColor = 32'hFF000080;
			cssStylePkg::identOlive: tableColor = 32'hFF808000;
			cssStylePkg::identOrange: tableColor = 32'hFFFFA500;
			cssStylePkg::identPurple: tableColor = 32'hFF800080;
			cssStylePkg::identRed: tableColor = 32'hFFFF0000;
			cssStylePkg::identSilver: tableColor = 32'hFFC0C0C0;
			cssStylePkg::identTeal: tableColor = 32'hFF008080;
			cssStylePkg::identTransparent: tableColor = 32'h00000000; // alpha zero
			cssStylePkg::identWhite: tableColor = 32'hFFFFFFFF;
			cssStylePkg::identYellow: tableColor = 32'hFFFFFF00;
			// system theme entries follow the default theme
			cssStylePkg::identActiveborder: tableColor = 32'hFFFFFFFF;
			cssStylePkg::identActivecaption: tableColor = 32'hFFCCCCCC;
			cssStylePkg::identAppworkspace: tableColor = 32'hFFFFFFFF;
			cssStylePkg::identBackground: tableColor = 32'hFF6363CE;
			cssStylePkg::identButtonface: tableColor = 32'hFFC0C0C0;
			cssStylePkg::identButtonhighlight: tableColor = 32'hFFDDDDDD;
			cssStylePkg::identButtonshadow: tableColor = 32'hFF888888;
			cssStylePkg::identButtontext: tableColor = 32'hFF000000;
			cssStylePkg::identCaptiontext: tableColor = 32'hFF000000;
			cssStylePkg::identGraytext: tableColor = 32'hFF808080;
			cssStylePkg::identHighlight: tableColor = 32'hFFB5D5FF;
			cssStylePkg::identHighlighttext: tableColor = 32'hFF000000;
			cssStylePkg::identInactiveborder: tableColor = 32'hFFFFFFFF;
			cssStylePkg::identInactivecaption: tableColor = 32'hFFFFFFFF;
			cssStylePkg::identInactivecaptiontext: tableColor = 32'hFF7F7F7F;
			cssStylePkg::identInfobackground: tableColor = 32'hFFFBFCC5;
			cssStylePkg::identInfotext: tableColor = 32'hFF000000;
			cssStylePkg::identMenu: tableColor = 32'hFFC0C0C0;
			default: tableColor = 32'h00000000; // menutext, keywords and unknown codes
		endcase
	end

	// one cycle from lookupIdent to namedColor
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			namedColor <= '0;
		end
		else
		begin
			namedColor <= tableColor;
		end
	end

endmodule

// File: logic/cssStylePkg.sv
package cssStylePkg;

	typedef logic [9:0] cssIdentT; // css value identifier
	typedef logic [6:0] unitTypeT; // primitive unit type

	// ARGB color with alpha in the top byte
	typedef struct packed
	{
		logic [7:0] alpha;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbaT;

	localparam unitTypeT unitIdent = 7'd21; // value is an identifier
	localparam unitTypeT unitRgbColor = 7'd25; // value is an rgb color

	localparam cssIdentT identNone = 10'd0;

	// named colors
	localparam cssIdentT identAqua = 10'd1;
	localparam cssIdentT identBlack = 10'd2;
	localparam cssIdentT identBlue = 10'd3;
	localparam cssIdentT identFuchsia = 10'd4;
	localparam cssIdentT identGray = 10'd5;
	localparam cssIdentT identGreen = 10'd6;
	localparam cssIdentT identGrey = 10'd7;
	localparam cssIdentT identLime = 10'd8;
	localparam cssIdentT identMaroon = 10'd9;
	localparam cssIdentT identNavy = 10'd10;
	localparam cssIdentT identOlive = 10'd11;
	localparam cssIdentT identOrange = 10'd12;
	localparam cssIdentT identPurple = 10'd13;
	localparam cssIdentT identRed = 10'd14;
	localparam cssIdentT identSilver = 10'd15;
	localparam cssIdentT identTeal = 10'd16;
	localparam cssIdentT identTransparent = 10'd17;
	localparam cssIdentT identWhite = 10'd18;
	localparam cssIdentT identYellow = 10'd19;

	// system theme colors
	localparam cssIdentT identActiveborder = 10'd20;
	localparam cssIdentT identActivecaption = 10'd21;
	localparam cssIdentT identAppworkspace = 10'd22;
	localparam cssIdentT identBackground = 10'd23;
	localparam cssIdentT identButtonface = 10'd24;
	localparam cssIdentT identButtonhighlight = 10'd25;
	localparam cssIdentT identButtonshadow = 10'd26;
	localparam cssIdentT identButtontext = 10'd27;
	localparam cssIdentT identCaptiontext = 10'd28;
	localparam cssIdentT identGraytext = 10'd29;
	localparam cssIdentT identHighlight = 10'd30;
	localparam cssIdentT identHighlighttext = 10'd31;
	localparam cssIdentT identInactiveborder = 10'd32;
	localparam cssIdentT identInactivecaption = 10'd33;
	localparam cssIdentT identInactivecaptiontext = 10'd34;
	localparam cssIdentT identInfobackground = 10'd35;
	localparam cssIdentT identInfotext = 10'd36;
	localparam cssIdentT identMenu = 10'd37;
	localparam cssIdentT identMenutext = 10'd38; // no table entry so it resolves to 0

	// document keywords
	localparam cssIdentT identWebkitText = 10'd39;
	localparam cssIdentT identWebkitLink = 10'd40;
	localparam cssIdentT identWebkitActivelink = 10'd41;
	localparam cssIdentT identWebkitFocusRingColor = 10'd42;
	localparam cssIdentT identCurrentcolor = 10'd43;

	// one primitive value plus link flags
	typedef struct packed
	{
		unitTypeT unitType;
		cssIdentT valueIdent; // only meaningful for unitIdent
		rgbaT rgbColor; // only meaningful for unitRgbColor
		logic isLinkElement;
		logic forVisitedLink;
	} styleRequestT;

	// colors taken from the document and parent style
	typedef struct packed
	{
		rgbaT textColor;
		rgbaT linkColor;
		rgbaT visitedLinkColor;
		rgbaT activeLinkColor;
		rgbaT inheritedColor;
	} documentColorsT;

	// request controller states
	typedef enum logic [1:0]
	{
		stateIdle,
		stateLookup,
		stateResolve,
		stateHold
	} ctrlStateT;

endpackage
